//--- Makefile
VERILATOR ?= verilator
TOP       := tb_gat_attention
FILELIST  := sim.f
BUILD_DIR := obj_dir
LOG       := sim.log
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(BUILD_DIR)
LINTFLAGS := --lint-only --timing -Wall --top-module $(TOP)
PASS_MSG  := Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# the log decides pass or fail
run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "run failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- include/gat_defs.svh
`ifndef GAT_DEFS_SVH
`define GAT_DEFS_SVH

// element width, shared by a, row data and coefficients
`define GAT_DATA_WIDTH 8

// full attention vector, half of it is used per row
`define GAT_A_DEPTH 8

// nodes per subgraph, also the number of coefficient lanes
`define GAT_MAX_NODES 8

// width of a node count field
`define GAT_NODE_CNT_WIDTH 4

// signed width of products, tree sums and scores
`define GAT_SCORE_WIDTH 20

// row memory depth
`define GAT_WH_DEPTH 64

// coefficient memory depth, max subgraphs per run
`define GAT_COEF_DEPTH 16

// width of the subgraph count at start
`define GAT_SG_CNT_WIDTH 5

// right shift of a summed score before truncation
`define GAT_SCORE_SHIFT 4

`endif

//--- sim.f
+incdir+include
src/gat_arith_pkg.sv
src/gat_mem_pkg.sv
src/gat_ram.sv
src/attention_dmvm.sv
src/subgraph_sequencer.sv
src/gat_attention_top.sv
tests/gat_coef_model.sv
tests/tb_gat_attention.sv

//--- src/attention_dmvm.sv
`include "gat_defs.svh"

module attention_dmvm (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      a_valid_i,
  input  gat_arith_pkg::a_vec_t     a_i,
  input  logic                      row_valid_i,
  input  logic                      row_last_i,
  input  gat_mem_pkg::wh_word_t     row_i,
  output logic                      coef_valid_o,
  output gat_arith_pkg::coef_vec_t  coef_o,
  output gat_arith_pkg::node_cnt_t  num_nodes_o
);

  import gat_arith_pkg::*;
  import gat_mem_pkg::*;

  localparam int HALF = `GAT_A_DEPTH / 2;
  localparam int IDX_W = $clog2(`GAT_MAX_NODES);

  a_vec_t                         a_q;
  data_t     [HALF-1:0]           a_sel;
  node_cnt_t                      next_idx_q;
  node_cnt_t                      row_idx;

  // stage 1, products
  logic                           s1_valid;
  logic                           s1_last;
  score_t    [HALF-1:0]           s1_prod;
  node_cnt_t                      s1_idx;
  node_cnt_t                      s1_cnt;

  // stage 2, pair sums
  logic                           s2_valid;
  logic                           s2_last;
  score_t    [HALF/2-1:0]         s2_sum;
  node_cnt_t                      s2_idx;
  node_cnt_t                      s2_cnt;

  // stage 3, score store
  score_t    [`GAT_MAX_NODES-1:0] score_q;
  logic                           s3_last;
  node_cnt_t                      s3_cnt;

  // activation
  score_t    [`GAT_MAX_NODES-1:0] act_sum;
  coef_vec_t                      act_coef;

  always_ff @(posedge clk) begin
    if (a_valid_i) begin
      a_q <= a_i;
    end
  end

  // source row takes the lower half of a
  always_comb begin
    for (int i = 0; i < HALF; i++) begin
      a_sel[i] = row_i.src ? a_q[i] : a_q[i+HALF];
    end
  end

  assign row_idx = row_i.src ? '0 : next_idx_q;

  // valid/last tags and node index
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      next_idx_q <= '0;
      s1_valid   <= 1'b0;
      s1_last    <= 1'b0;
      s2_valid   <= 1'b0;
      s2_last    <= 1'b0;
      s3_last    <= 1'b0;
    end else begin
      if (row_valid_i) begin
        next_idx_q <= row_idx + 1'b1;
      end
      s1_valid <= row_valid_i;
      s1_last  <= row_valid_i && row_last_i;
      s2_valid <= s1_valid;
      s2_last  <= s1_last;
      s3_last  <= s2_last;
    end
  end

  always_ff @(posedge clk) begin
    if (row_valid_i) begin
      for (int i = 0; i < HALF; i++) begin
        s1_prod[i] <= $signed(a_sel[i]) * $signed(row_i.elem[i]);
      end
      s1_idx <= row_idx;
      s1_cnt <= row_i.cnt;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      s2_sum[0] <= s1_prod[0] + s1_prod[1];
      s2_sum[1] <= s1_prod[2] + s1_prod[3];
      s2_idx    <= s1_idx;
      s2_cnt    <= s1_cnt;
    end
  end

  always_ff @(posedge clk) begin
    if (s2_valid) begin
      score_q[s2_idx[IDX_W-1:0]] <= s2_sum[0] + s2_sum[1];
    end
    if (s2_last) begin
      s3_cnt <= s2_cnt;
    end
  end

  // lane k: relu(score 0 + score k) >> shift, lanes past the count read 0
  always_comb begin
    for (int k = 0; k < `GAT_MAX_NODES; k++) begin
      act_sum[k] = score_q[0] + score_q[k];
      if ((k >= int'(s3_cnt)) || (act_sum[k] < 0)) begin
        act_coef[k] = '0;
      end else begin
        act_coef[k] = act_sum[k][`GAT_SCORE_SHIFT +: `GAT_DATA_WIDTH];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      coef_valid_o <= 1'b0;
    end else begin
      coef_valid_o <= s3_last;
    end
  end

  always_ff @(posedge clk) begin
    if (s3_last) begin
      coef_o      <= act_coef;
      num_nodes_o <= s3_cnt;
    end
  end

  // a reload mid-run would mix two vectors within one subgraph
  a_no_reload_in_flight: assert property (
    @(posedge clk) disable iff (!rst_n)
    a_valid_i |-> !(row_valid_i || s1_valid || s2_valid)
  ) else $error("attention_dmvm: a reloaded while rows are in flight");

  a_node_idx_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    row_valid_i |-> (int'(row_idx) <= `GAT_MAX_NODES - 1)
  ) else $error("attention_dmvm: node index %0d out of range", row_idx);

endmodule

//--- src/gat_arith_pkg.sv
`include "gat_defs.svh"

package gat_arith_pkg;

  // one signed element of a or of a row
  typedef logic signed [`GAT_DATA_WIDTH-1:0] data_t;

  // whole attention vector, lower half for the source node
  typedef data_t [`GAT_A_DEPTH-1:0] a_vec_t;

  // products, pair sums and node scores share one width
  typedef logic signed [`GAT_SCORE_WIDTH-1:0] score_t;

  // unsigned coefficients after ReLU and shift
  typedef logic [`GAT_MAX_NODES-1:0][`GAT_DATA_WIDTH-1:0] coef_vec_t;

  // node count, 1 up to GAT_MAX_NODES
  typedef logic [`GAT_NODE_CNT_WIDTH-1:0] node_cnt_t;

endpackage

//--- src/gat_attention_top.sv
`include "gat_defs.svh"

module gat_attention_top (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          wh_we_i,
  input  gat_mem_pkg::wh_addr_t         wh_waddr_i,
  input  gat_mem_pkg::wh_word_t         wh_wdata_i,
  input  logic                          a_valid_i,
  input  gat_arith_pkg::a_vec_t         a_i,
  input  logic                          start_i,
  input  gat_mem_pkg::wh_addr_t         wh_base_i,
  input  logic [`GAT_SG_CNT_WIDTH-1:0]  num_subgraphs_i,
  input  gat_mem_pkg::coef_addr_t       coef_raddr_i,
  output gat_mem_pkg::coef_entry_t      coef_rdata_o,
  output logic                          busy_o,
  output logic                          done_o
);

  import gat_arith_pkg::*;
  import gat_mem_pkg::*;

  // row memory read side
  logic         wh_re;
  wh_addr_t     wh_raddr;
  wh_word_t     wh_rdata;

  // sequencer to dot-product unit
  logic         row_valid;
  logic         row_last;
  wh_word_t     row;

  // dot-product unit back to the sequencer
  logic         coef_valid;
  coef_vec_t    coef;
  node_cnt_t    num_nodes;

  // result memory write side
  logic         coef_we;
  coef_addr_t   coef_waddr;
  coef_entry_t  coef_wdata;

  gat_ram #(
    .DEPTH  (`GAT_WH_DEPTH),
    .word_t (wh_word_t)
  ) wh_ram_inst (
    .clk     (clk),
    .we_i    (wh_we_i),
    .waddr_i (wh_waddr_i),
    .wdata_i (wh_wdata_i),
    .re_i    (wh_re),
    .raddr_i (wh_raddr),
    .rdata_o (wh_rdata)
  );

  subgraph_sequencer subgraph_sequencer_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .start_i         (start_i),
    .wh_base_i       (wh_base_i),
    .num_subgraphs_i (num_subgraphs_i),
    .rd_en_o         (wh_re),
    .rd_addr_o       (wh_raddr),
    .rd_word_i       (wh_rdata),
    .row_valid_o     (row_valid),
    .row_last_o      (row_last),
    .row_o           (row),
    .coef_valid_i    (coef_valid),
    .coef_i          (coef),
    .num_nodes_i     (num_nodes),
    .coef_we_o       (coef_we),
    .coef_waddr_o    (coef_waddr),
    .coef_wdata_o    (coef_wdata),
    .busy_o          (busy_o),
    .done_o          (done_o)
  );

  attention_dmvm attention_dmvm_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .a_valid_i    (a_valid_i),
    .a_i          (a_i),
    .row_valid_i  (row_valid),
    .row_last_i   (row_last),
    .row_i        (row),
    .coef_valid_o (coef_valid),
    .coef_o       (coef),
    .num_nodes_o  (num_nodes)
  );

  // host read port is always enabled
  gat_ram #(
    .DEPTH  (`GAT_COEF_DEPTH),
    .word_t (coef_entry_t)
  ) coef_ram_inst (
    .clk     (clk),
    .we_i    (coef_we),
    .waddr_i (coef_waddr),
    .wdata_i (coef_wdata),
    .re_i    (1'b1),
    .raddr_i (coef_raddr_i),
    .rdata_o (coef_rdata_o)
  );

endmodule

//--- src/gat_mem_pkg.sv
`include "gat_defs.svh"

package gat_mem_pkg;

  // one stored row, the count is repeated in every row of a subgraph
  typedef struct packed {
    logic                                       src;
    gat_arith_pkg::node_cnt_t                   cnt;
    gat_arith_pkg::data_t [`GAT_A_DEPTH/2-1:0]  elem;
  } wh_word_t;

  // one result entry
  typedef struct packed {
    gat_arith_pkg::node_cnt_t   cnt;
    gat_arith_pkg::coef_vec_t   coef;
  } coef_entry_t;

  typedef logic [$clog2(`GAT_WH_DEPTH)-1:0]   wh_addr_t;
  typedef logic [$clog2(`GAT_COEF_DEPTH)-1:0] coef_addr_t;

endpackage

//--- src/gat_ram.sv
module gat_ram #(
  parameter int  DEPTH  = 16,
  parameter type word_t = logic [7:0]
) (
  input  logic                     clk,
  input  logic                     we_i,
  input  logic [$clog2(DEPTH)-1:0] waddr_i,
  input  word_t                    wdata_i,
  input  logic                     re_i,
  input  logic [$clog2(DEPTH)-1:0] raddr_i,
  output word_t                    rdata_o
);

  word_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // registered read, output holds while re_i is low
  always_ff @(posedge clk) begin
    if (re_i) begin
      rdata_o <= mem[raddr_i];
    end
  end

  a_waddr_in_range: assert property (
    @(posedge clk) we_i |-> (int'(waddr_i) < DEPTH)
  ) else $error("gat_ram: write address %0d beyond depth %0d", waddr_i, DEPTH);

  a_raddr_in_range: assert property (
    @(posedge clk) re_i |-> (int'(raddr_i) < DEPTH)
  ) else $error("gat_ram: read address %0d beyond depth %0d", raddr_i, DEPTH);

endmodule

//--- src/subgraph_sequencer.sv
`include "gat_defs.svh"

module subgraph_sequencer (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          start_i,
  input  gat_mem_pkg::wh_addr_t         wh_base_i,
  input  logic [`GAT_SG_CNT_WIDTH-1:0]  num_subgraphs_i,
  output logic                          rd_en_o,
  output gat_mem_pkg::wh_addr_t         rd_addr_o,
  input  gat_mem_pkg::wh_word_t         rd_word_i,
  output logic                          row_valid_o,
  output logic                          row_last_o,
  output gat_mem_pkg::wh_word_t         row_o,
  input  logic                          coef_valid_i,
  input  gat_arith_pkg::coef_vec_t      coef_i,
  input  gat_arith_pkg::node_cnt_t      num_nodes_i,
  output logic                          coef_we_o,
  output gat_mem_pkg::coef_addr_t       coef_waddr_o,
  output gat_mem_pkg::coef_entry_t      coef_wdata_o,
  output logic                          busy_o,
  output logic                          done_o
);

  import gat_arith_pkg::*;
  import gat_mem_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_HEAD, ST_STREAM, ST_DRAIN} state_t;

  state_t                         state_q;
  wh_addr_t                       addr_q;
  node_cnt_t                      rows_left_q;
  logic [`GAT_SG_CNT_WIDTH-1:0]   sg_left_q;
  logic [`GAT_SG_CNT_WIDTH-1:0]   wr_left_q;
  coef_addr_t                     coef_waddr_q;
  logic                           rd_valid_q;
  logic                           head_pend_q;
  logic                           last_pend_q;
  logic                           rd_last;

  // head read in ST_HEAD, no read while its count comes back
  always_comb begin
    rd_en_o = 1'b0;
    rd_last = 1'b0;
    if (state_q == ST_HEAD) begin
      rd_en_o = 1'b1;
    end else if ((state_q == ST_STREAM) && !head_pend_q) begin
      rd_en_o = 1'b1;
      rd_last = (rows_left_q == 4'd1);
    end
  end

  assign rd_addr_o   = addr_q;
  assign row_valid_o = rd_valid_q;
  assign row_o       = rd_word_i;
  // a one-node subgraph ends on its head
  assign row_last_o  = rd_valid_q && (head_pend_q ? (rd_word_i.cnt == 4'd1) : last_pend_q);

  assign coef_we_o    = coef_valid_i;
  assign coef_waddr_o = coef_waddr_q;
  assign coef_wdata_o = '{cnt: num_nodes_i, coef: coef_i};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q      <= ST_IDLE;
      addr_q       <= '0;
      rows_left_q  <= '0;
      sg_left_q    <= '0;
      wr_left_q    <= '0;
      coef_waddr_q <= '0;
      rd_valid_q   <= 1'b0;
      head_pend_q  <= 1'b0;
      last_pend_q  <= 1'b0;
      busy_o       <= 1'b0;
      done_o       <= 1'b0;
    end else begin
      done_o      <= 1'b0;
      rd_valid_q  <= rd_en_o;
      head_pend_q <= (state_q == ST_HEAD);
      last_pend_q <= rd_last;
      if (coef_valid_i) begin
        coef_waddr_q <= coef_waddr_q + 1'b1;
        wr_left_q    <= wr_left_q - 1'b1;
      end
      case (state_q)
        ST_IDLE: begin
          if (start_i) begin
            addr_q       <= wh_base_i;
            sg_left_q    <= num_subgraphs_i;
            wr_left_q    <= num_subgraphs_i;
            coef_waddr_q <= '0;
            busy_o       <= 1'b1;
            state_q      <= ST_HEAD;
          end
        end
        ST_HEAD: begin
          addr_q    <= addr_q + 1'b1;
          sg_left_q <= sg_left_q - 1'b1;
          state_q   <= ST_STREAM;
        end
        ST_STREAM: begin
          if (head_pend_q) begin
            rows_left_q <= rd_word_i.cnt - 4'd1;
            if (rd_word_i.cnt == 4'd1) begin
              state_q <= (sg_left_q == '0) ? ST_DRAIN : ST_HEAD;
            end
          end else begin
            addr_q      <= addr_q + 1'b1;
            rows_left_q <= rows_left_q - 4'd1;
            if (rd_last) begin
              state_q <= (sg_left_q == '0) ? ST_DRAIN : ST_HEAD;
            end
          end
        end
        default: begin
          // wait for the final coefficient write
          if (coef_valid_i && (wr_left_q == 5'd1)) begin
            done_o  <= 1'b1;
            busy_o  <= 1'b0;
            state_q <= ST_IDLE;
          end
        end
      endcase
    end
  end

  a_sg_count_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    (start_i && (state_q == ST_IDLE)) |->
      (num_subgraphs_i inside {[1:`GAT_COEF_DEPTH]})
  ) else $error("subgraph_sequencer: subgraph count %0d out of range", num_subgraphs_i);

  a_head_is_source: assert property (
    @(posedge clk) disable iff (!rst_n)
    head_pend_q |-> rd_word_i.src
  ) else $error("subgraph_sequencer: head row without source flag");

endmodule

//--- tests/gat_coef_model.sv
`include "gat_defs.svh"

module gat_coef_model (
  input  gat_arith_pkg::a_vec_t     a_i,
  input  gat_arith_pkg::node_cnt_t  cnt_i,
  input  gat_mem_pkg::wh_word_t     rows_i [`GAT_MAX_NODES],
  output gat_mem_pkg::coef_entry_t  entry_o
);

  timeunit 1ns;
  timeprecision 100ps;

  import gat_arith_pkg::*;
  import gat_mem_pkg::*;

  always_comb begin
    int          score [`GAT_MAX_NODES];
    int          sum;
    logic [31:0] shifted;
    entry_o     = '0;
    entry_o.cnt = cnt_i;
    // per node dot product with one half of a
    for (int n = 0; n < `GAT_MAX_NODES; n++) begin
      score[n] = 0;
      for (int i = 0; i < `GAT_A_DEPTH / 2; i++) begin
        if (rows_i[n].src) begin
          score[n] += int'(a_i[i]) * int'(rows_i[n].elem[i]);
        end else begin
          score[n] += int'(a_i[i + `GAT_A_DEPTH / 2]) * int'(rows_i[n].elem[i]);
        end
      end
    end
    // relu on source plus neighbour, then shift and keep the low byte
    for (int k = 0; k < `GAT_MAX_NODES; k++) begin
      sum     = score[0] + score[k];
      shifted = sum >>> `GAT_SCORE_SHIFT;
      if ((k < int'(cnt_i)) && (sum >= 0)) begin
        entry_o.coef[k] = shifted[`GAT_DATA_WIDTH-1:0];
      end
    end
  end

endmodule

//--- tests/tb_gat_attention.sv
`include "gat_defs.svh"

module tb_gat_attention;

  timeunit 1ns;
  timeprecision 100ps;

  import gat_arith_pkg::*;
  import gat_mem_pkg::*;

  localparam int TIMEOUT = 1000;

  logic                          clk;
  logic                          rst_n;
  logic                          wh_we_i;
  wh_addr_t                      wh_waddr_i;
  wh_word_t                      wh_wdata_i;
  logic                          a_valid_i;
  a_vec_t                        a_i;
  logic                          start_i;
  wh_addr_t                      wh_base_i;
  logic [`GAT_SG_CNT_WIDTH-1:0]  num_subgraphs_i;
  coef_addr_t                    coef_raddr_i;
  coef_entry_t                   coef_rdata_o;
  logic                          busy_o;
  logic                          done_o;

  int           seed;
  int           cycle_cnt = 0;
  int           done_cnt = 0;
  int           runs_expected = 0;
  logic         started;
  a_vec_t       cur_a;
  wh_word_t     wh_copy [`GAT_WH_DEPTH];
  wh_word_t     new_rows [`GAT_MAX_NODES];
  wh_word_t     model_rows [`GAT_MAX_NODES];
  node_cnt_t    model_cnt;
  a_vec_t       model_a;
  coef_entry_t  model_entry;
  coef_entry_t  exp_q [$];

  gat_attention_top gat_attention_top_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .wh_we_i         (wh_we_i),
    .wh_waddr_i      (wh_waddr_i),
    .wh_wdata_i      (wh_wdata_i),
    .a_valid_i       (a_valid_i),
    .a_i             (a_i),
    .start_i         (start_i),
    .wh_base_i       (wh_base_i),
    .num_subgraphs_i (num_subgraphs_i),
    .coef_raddr_i    (coef_raddr_i),
    .coef_rdata_o    (coef_rdata_o),
    .busy_o          (busy_o),
    .done_o          (done_o)
  );

  gat_coef_model gat_coef_model_inst (
    .a_i     (model_a),
    .cnt_i   (model_cnt),
    .rows_i  (model_rows),
    .entry_o (model_entry)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (rst_n && done_o) begin
      done_cnt <= done_cnt + 1;
    end
  end

  task automatic abort_sim(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [127:0] exp,
                             input logic [127:0] act);
    assert (act === exp)
      else abort_sim($sformatf("error: %s expected %0h actual %0h", name, exp, act));
  endtask

  // first sample after power-up is still unreset
  a_quiet_before_start: assert property (
    @(posedge clk) ((cycle_cnt > 0) && !started) |-> (!busy_o && !done_o)
  ) else abort_sim("busy_o or done_o went high before the first start");

  a_busy_ends_with_done: assert property (
    @(posedge clk) disable iff (!rst_n) $fell(busy_o) |-> done_o
  ) else abort_sim("busy_o dropped without a done_o pulse");

  a_done_single_pulse: assert property (
    @(posedge clk) disable iff (!rst_n) done_o |=> !done_o
  ) else abort_sim("done_o stayed high for more than one cycle");

  function automatic data_t rand_elem();
    return data_t'($random(seed));
  endfunction

  function automatic a_vec_t random_a();
    a_vec_t vec;
    for (int i = 0; i < `GAT_A_DEPTH; i++) begin
      vec[i] = rand_elem();
    end
    return vec;
  endfunction

  task automatic load_a(input a_vec_t vec);
    @(posedge clk);
    #1;
    a_valid_i = 1'b1;
    a_i       = vec;
    cur_a     = vec;
    @(posedge clk);
    #1;
    a_valid_i = 1'b0;
  endtask

  task automatic fill_random_rows(input node_cnt_t cnt);
    for (int n = 0; n < `GAT_MAX_NODES; n++) begin
      new_rows[n].src = (n == 0);
      new_rows[n].cnt = cnt;
      for (int i = 0; i < `GAT_A_DEPTH / 2; i++) begin
        new_rows[n].elem[i] = rand_elem();
      end
    end
  endtask

  task automatic store_rows(input wh_addr_t base, input node_cnt_t cnt);
    for (int n = 0; n < int'(cnt); n++) begin
      @(posedge clk);
      #1;
      wh_we_i    = 1'b1;
      wh_waddr_i = base + wh_addr_t'(n);
      wh_wdata_i = new_rows[n];
      wh_copy[base + wh_addr_t'(n)] = new_rows[n];
    end
    @(posedge clk);
    #1;
    wh_we_i = 1'b0;
  endtask

  // model output settles within the 1 ns step
  task automatic expect_subgraph(input wh_addr_t base, input node_cnt_t cnt);
    model_a   = cur_a;
    model_cnt = cnt;
    for (int n = 0; n < `GAT_MAX_NODES; n++) begin
      if (n < int'(cnt)) begin
        model_rows[n] = wh_copy[base + wh_addr_t'(n)];
      end else begin
        model_rows[n] = '0;
      end
    end
    #1;
    exp_q.push_back(model_entry);
  endtask

  task automatic start_run(input wh_addr_t base, input logic [`GAT_SG_CNT_WIDTH-1:0] nsg);
    @(posedge clk);
    #1;
    start_i         = 1'b1;
    wh_base_i       = base;
    num_subgraphs_i = nsg;
    started         = 1'b1;
    @(posedge clk);
    #1;
    start_i = 1'b0;
  endtask

  task automatic wait_done();
    int n;
    n = 0;
    while (done_o !== 1'b1) begin
      if (n == TIMEOUT) begin
        abort_sim("timeout while waiting for done_o");
      end
      assert (busy_o === 1'b1) else abort_sim("busy_o low while a run is in progress");
      n++;
      @(posedge clk);
      #1;
    end
  endtask

  // idle a while so a stray second done_o would be counted
  task automatic settle_and_count();
    repeat (8) @(posedge clk);
    #1;
    runs_expected++;
    check_value("done_pulses", runs_expected, done_cnt);
  endtask

  task automatic check_entries(input string name, input int n);
    coef_entry_t exp;
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      #1;
      coef_raddr_i = coef_addr_t'(i);
      @(posedge clk);
      #1;
      exp = exp_q.pop_front();
      check_value($sformatf("%s[%0d]", name, i), exp, coef_rdata_o);
    end
  endtask

  task automatic expect_three_subgraphs();
    expect_subgraph(6'd10, 4'd1);
    expect_subgraph(6'd11, 4'd3);
    expect_subgraph(6'd14, 4'd5);
  endtask

  initial begin
    a_vec_t relu_a;
    seed            = 32'h77c8;
    clk             = 1'b0;
    rst_n           = 1'b0;
    wh_we_i         = 1'b0;
    wh_waddr_i      = '0;
    wh_wdata_i      = '0;
    a_valid_i       = 1'b0;
    a_i             = '0;
    start_i         = 1'b0;
    wh_base_i       = '0;
    num_subgraphs_i = '0;
    coef_raddr_i    = '0;
    started         = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // one full 8-node subgraph
    load_a(random_a());
    fill_random_rows(4'd8);
    store_rows(6'd0, 4'd8);
    expect_subgraph(6'd0, 4'd8);
    start_run(6'd0, 5'd1);
    wait_done();
    settle_and_count();
    check_entries("single_sg", 1);

    // counts 1, 3 and 5 back to back from row 10
    fill_random_rows(4'd1);
    store_rows(6'd10, 4'd1);
    fill_random_rows(4'd3);
    store_rows(6'd11, 4'd3);
    fill_random_rows(4'd5);
    store_rows(6'd14, 4'd5);
    expect_three_subgraphs();
    start_run(6'd10, 5'd3);
    wait_done();
    settle_and_count();
    check_entries("multi_sg", 3);

    // positive source half against a strongly negative neighbour half
    for (int i = 0; i < `GAT_A_DEPTH / 2; i++) begin
      relu_a[i]                    = 8'sd60;
      relu_a[i + `GAT_A_DEPTH / 2] = -8'sd90;
    end
    load_a(relu_a);
    fill_random_rows(4'd4);
    for (int i = 0; i < `GAT_A_DEPTH / 2; i++) begin
      new_rows[0].elem[i] = 8'sd1;
      new_rows[1].elem[i] = 8'sd20;
      new_rows[2].elem[i] = -8'sd20;
    end
    store_rows(6'd20, 4'd4);
    expect_subgraph(6'd20, 4'd4);
    start_run(6'd20, 5'd1);
    wait_done();
    settle_and_count();
    check_entries("relu_sg", 1);

    // same rows with a new vector
    load_a(random_a());
    expect_three_subgraphs();
    start_run(6'd10, 5'd3);
    wait_done();
    settle_and_count();
    check_entries("reload_a", 3);

    // second start during a run must be dropped
    load_a(random_a());
    expect_three_subgraphs();
    start_run(6'd10, 5'd3);
    repeat (3) @(posedge clk);
    #1;
    check_value("busy_before_restart", 1, busy_o);
    start_run(6'd0, 5'd1);
    wait_done();
    settle_and_count();
    check_entries("start_while_busy", 3);

    $display("Simulation completed successfully");
    $finish;
  end

endmodule
